//--- build.f
rtl/igr_cfg_pkg.sv
rtl/igr_types_pkg.sv
rtl/igr_tag_if.sv
rtl/igr_rx_parser.sv
rtl/igr_tag_fifo.sv
rtl/igr_tag_arb.sv
rtl/igr_top.sv
tb/igr_assertions.sv
tb/igr_tb.sv

//--- Makefile
# Verilator build and run for the ingress front end

VERILATOR ?= verilator
TOP       ?= igr_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/igr_tb.sv
// Ingress front end testbench
// Drives all receive ports from a packet table, predicts one tag per packet
// from the framing rules and checks the merged tag stream per port

`timescale 1ns/100ps

module igr_tb;

  import igr_cfg_pkg::*;

  localparam int NUM_PORTS  = 4;
  localparam int MAX_LEN    = 64;
  localparam int FIFO_DEPTH = 4;
  localparam int NUM_TESTS  = 5;
  localparam int MAX_ENTRIES = 32;
  localparam int BEAT_MAX   = 256;
  localparam int EXP_MAX    = 64;

  typedef enum int {FK_GOOD, FK_NO_SOP, FK_DOUBLE_SOP, FK_TOO_LONG} frame_kind_e;

  typedef struct packed {
    int          test;
    int          port;
    int          dst;
    int          len;
    frame_kind_e kind;
    int          gap;
    int          reps;
  } stim_t;

  logic                             ingress_clock;
  logic                             reset;
  logic [NUM_PORTS-1:0]             rx_valid;
  logic [NUM_PORTS-1:0]             rx_sop;
  logic [NUM_PORTS-1:0]             rx_eop;
  logic [NUM_PORTS-1:0][DATA_W-1:0] rx_data;
  logic                             tag_valid;
  logic [PORT_W-1:0]                tag_src;
  logic [PORT_W-1:0]                tag_dst;
  logic [LEN_W-1:0]                 tag_len;
  logic                             tag_err;
  logic [15:0]                      tag_drops;

  // Packet table and per-test info
  stim_t       stim [MAX_ENTRIES];
  int          n_entries;
  string       test_name [NUM_TESTS];
  bit          test_loose [NUM_TESTS];

  // Per-port beat streams for the running test
  logic              bv [NUM_PORTS][BEAT_MAX];
  logic              bs [NUM_PORTS][BEAT_MAX];
  logic              be [NUM_PORTS][BEAT_MAX];
  logic [DATA_W-1:0] bd [NUM_PORTS][BEAT_MAX];
  int                beat_cnt [NUM_PORTS];

  // Per-port expected tag queues
  int exp_dst [NUM_PORTS][EXP_MAX];
  int exp_len [NUM_PORTS][EXP_MAX];
  int exp_err [NUM_PORTS][EXP_MAX];
  int exp_head [NUM_PORTS];
  int exp_tail [NUM_PORTS];
  int exp_cnt;

  logic [31:0] rng_state;
  int          rcv_cnt;
  bit          loose;
  int          errors;
  int          checks;
  int          tests_passed;
  int          cycle_cnt;
  int          cycle_limit;

  igr_top #(
    .NUM_PORTS  (NUM_PORTS),
    .MAX_LEN    (MAX_LEN),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .ingress_clock (ingress_clock),
    .reset         (reset),
    .rx_valid      (rx_valid),
    .rx_sop        (rx_sop),
    .rx_eop        (rx_eop),
    .rx_data       (rx_data),
    .tag_valid     (tag_valid),
    .tag_src       (tag_src),
    .tag_dst       (tag_dst),
    .tag_len       (tag_len),
    .tag_err       (tag_err),
    .tag_drops     (tag_drops)
  );

  // 100 ns clock
  always #50 ingress_clock = ~ingress_clock;

  // ============================================================
  // Stimulus building
  // ============================================================

  function automatic logic [31:0] next_random(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic add_entry(input int t, input int p, input int d, input int l,
                           input frame_kind_e k, input int g, input int r);
    stim[n_entries] = '{t, p, d, l, k, g, r};
    n_entries++;
  endtask

  task automatic add_beat(input int p, input logic v, input logic s, input logic e,
                          input logic [DATA_W-1:0] d);
    bv[p][beat_cnt[p]] = v;
    bs[p][beat_cnt[p]] = s;
    be[p][beat_cnt[p]] = e;
    bd[p][beat_cnt[p]] = d;
    beat_cnt[p]++;
  endtask

  task automatic expect_tag(input int p, input int d, input int l, input int e);
    exp_dst[p][exp_tail[p]] = d;
    exp_len[p][exp_tail[p]] = l;
    exp_err[p][exp_tail[p]] = e;
    exp_tail[p]++;
    exp_cnt++;
  endtask

  // One packet plus its idle gap, and the tags it should yield
  task automatic add_packet(input int p, input int dst, input int len,
                            input frame_kind_e kind, input int gap);
    int                w;
    int                half;
    logic [DATA_W-1:0] word;
    logic              sop;
    logic              eop;
    half = len / 2;
    for (w = 0; w < len; w++) begin
      rng_state = next_random(rng_state);
      word = rng_state;
      sop  = (kind != FK_NO_SOP) && (w == 0);
      eop  = (w == len - 1);
      if (sop) word[DST_LSB +: PORT_W] = PORT_W'(dst);
      // Second sop mid-packet, new packet heads to the neighbour port
      if (kind == FK_DOUBLE_SOP && w == half) begin
        sop = 1'b1;
        word[DST_LSB +: PORT_W] = PORT_W'(dst ^ 1);
      end
      add_beat(p, 1'b1, sop, eop, word);
    end
    for (w = 0; w < gap; w++) add_beat(p, 1'b0, 1'b0, 1'b0, '0);
    if (kind == FK_NO_SOP) begin
      // Only the orphan eop makes a tag
      expect_tag(p, 0, 1, 1);
    end else if (kind == FK_DOUBLE_SOP) begin
      expect_tag(p, dst, half, 1);
      expect_tag(p, dst ^ 1, len - half, 0);
    end else begin
      // Overlong packets pin len at the limit
      expect_tag(p, dst, (len > MAX_LEN) ? MAX_LEN : len, (len > MAX_LEN) ? 1 : 0);
    end
  endtask

  task automatic build_test(input int t);
    int i;
    int r;
    int p;
    for (p = 0; p < NUM_PORTS; p++) begin
      beat_cnt[p] = 0;
      exp_head[p] = 0;
      exp_tail[p] = 0;
    end
    exp_cnt = 0;
    for (i = 0; i < n_entries; i++) begin
      if (stim[i].test == t) begin
        for (r = 0; r < stim[i].reps; r++) begin
          add_packet(stim[i].port, (stim[i].dst + r) % (1 << PORT_W), stim[i].len,
                     stim[i].kind, stim[i].gap);
        end
      end
    end
  endtask

  // ============================================================
  // Driver, all ports in lock step on the falling edge
  // ============================================================

  task automatic drive_test();
    int n;
    int p;
    int max_beats;
    max_beats = 0;
    for (p = 0; p < NUM_PORTS; p++) begin
      if (beat_cnt[p] > max_beats) max_beats = beat_cnt[p];
    end
    for (n = 0; n <= max_beats; n++) begin
      @(negedge ingress_clock);
      for (p = 0; p < NUM_PORTS; p++) begin
        if (n < beat_cnt[p]) begin
          rx_valid[p] = bv[p][n];
          rx_sop[p]   = bs[p][n];
          rx_eop[p]   = be[p][n];
          rx_data[p]  = bd[p][n];
        end else begin
          rx_valid[p] = 1'b0;
          rx_sop[p]   = 1'b0;
          rx_eop[p]   = 1'b0;
          rx_data[p]  = '0;
        end
      end
    end
  endtask

  // ============================================================
  // Monitor and scoreboard
  // ============================================================

  function automatic bit tag_matches(input int p, input int j);
    return int'(tag_dst) == exp_dst[p][j] && int'(tag_len) == exp_len[p][j] &&
           int'(tag_err) == exp_err[p][j];
  endfunction

  task automatic check_tag();
    int p;
    int j;
    bit found;
    p = int'(tag_src);
    rcv_cnt++;
    checks++;
    if (p >= NUM_PORTS) begin
      $display("FAIL @ %0t: tag from nonexistent port %0d", $time, p);
      errors++;
    end else if (loose) begin
      // Burst mode, dropped tags may be skipped
      found = 1'b0;
      j = exp_head[p];
      while (!found && j < exp_tail[p]) begin
        if (tag_matches(p, j)) found = 1'b1;
        else j++;
      end
      if (!found) begin
        $display("FAIL @ %0t: port %0d tag dst %0d len %0d err %0d not in expected order",
                 $time, p, tag_dst, tag_len, tag_err);
        errors++;
      end else begin
        exp_head[p] = j + 1;
      end
    end else if (exp_head[p] == exp_tail[p]) begin
      $display("FAIL @ %0t: unexpected tag from port %0d", $time, p);
      errors++;
    end else begin
      j = exp_head[p];
      if (!tag_matches(p, j)) begin
        $display("FAIL @ %0t: port %0d got dst %0d len %0d err %0d, want %0d %0d %0d",
                 $time, p, tag_dst, tag_len, tag_err,
                 exp_dst[p][j], exp_len[p][j], exp_err[p][j]);
        errors++;
      end
      exp_head[p]++;
    end
  endtask

  // Outputs are stable mid-cycle
  always @(negedge ingress_clock) begin
    if (!reset && tag_valid) check_tag();
  end

  // Run limit
  always @(posedge ingress_clock) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles: tags are missing, %0d of %0d received",
               cycle_cnt, rcv_cnt, exp_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ============================================================
  // Test sequence
  // ============================================================

  task automatic run_test(input int t);
    int err_start;
    int drops_start;
    int drops;
    build_test(t);
    @(posedge ingress_clock);
    rcv_cnt     = 0;
    loose       = test_loose[t];
    err_start   = errors;
    drops_start = int'(tag_drops);
    drive_test();
    while (rcv_cnt + int'(tag_drops) - drops_start < exp_cnt) @(posedge ingress_clock);
    // Settle, catches any stray tag
    repeat (8) @(negedge ingress_clock);
    drops = int'(tag_drops) - drops_start;
    checks++;
    if (!loose && drops != 0) begin
      $display("FAIL @ %0t: tag_drops rose by %0d under low load", $time, drops);
      errors++;
    end
    if (rcv_cnt + drops != exp_cnt) begin
      $display("FAIL @ %0t: %0d tags plus %0d drops, %0d packets sent",
               $time, rcv_cnt, drops, exp_cnt);
      errors++;
    end
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %0d %s: ok, %0d tags, %0d drops", t + 1, test_name[t], rcv_cnt, drops);
    end else begin
      $display("Test %0d %s: %0d errors", t + 1, test_name[t], errors - err_start);
    end
  endtask

  initial begin
    int t;
    int i;
    int total;
    ingress_clock = 1'b0;
    reset         = 1'b1;
    rx_valid      = '0;
    rx_sop        = '0;
    rx_eop        = '0;
    rx_data       = '0;
    rng_state     = 32'hee25_2c2c;
    n_entries     = 0;
    rcv_cnt       = 0;
    exp_cnt       = 0;
    loose         = 1'b0;
    errors        = 0;
    checks        = 0;
    tests_passed  = 0;
    cycle_cnt     = 0;

    // test, port, dst, len, kind, gap, reps
    add_entry(0, 0, 1, 1, FK_GOOD, 2, 1);
    add_entry(0, 1, 2, 5, FK_GOOD, 3, 1);
    add_entry(0, 2, 3, 1, FK_GOOD, 3, 1);
    add_entry(0, 3, 0, 7, FK_GOOD, 2, 1);
    add_entry(0, 2, 5, 4, FK_GOOD, 2, 1);
    for (i = 0; i < NUM_PORTS; i++) add_entry(1, i, i + 2, 3, FK_GOOD, 4, 3);
    add_entry(2, 0, 0, 3, FK_NO_SOP, 2, 1);
    add_entry(2, 1, 2, 6, FK_DOUBLE_SOP, 2, 1);
    add_entry(2, 2, 4, 4, FK_DOUBLE_SOP, 3, 1);
    add_entry(2, 3, 0, 1, FK_NO_SOP, 2, 1);
    add_entry(3, 0, 6, 65, FK_TOO_LONG, 2, 1);
    add_entry(3, 1, 3, 70, FK_TOO_LONG, 3, 1);
    add_entry(3, 3, 7, MAX_LEN, FK_GOOD, 2, 1);
    for (i = 0; i < NUM_PORTS; i++) add_entry(4, i, i, 1, FK_GOOD, 0, 12);

    test_name[0] = "good_packets";
    test_name[1] = "all_ports_low_load";
    test_name[2] = "framing_errors";
    test_name[3] = "overlong_packets";
    test_name[4] = "burst_overload";
    for (t = 0; t < NUM_TESTS; t++) test_loose[t] = (t == 4);

    // Words plus gaps, doubled, plus slack
    total = 0;
    for (i = 0; i < n_entries; i++) total += stim[i].reps * (stim[i].len + stim[i].gap);
    cycle_limit = 2 * total + 50;

    repeat (3) @(posedge ingress_clock);
    @(negedge ingress_clock);
    reset = 1'b0;

    for (t = 0; t < NUM_TESTS; t++) run_test(t);

    $display("Tests %0d, passed %0d, failed %0d; checks %0d, errors %0d",
             NUM_TESTS, tests_passed, NUM_TESTS - tests_passed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- tb/igr_assertions.sv
// Ingress output checks
// Concurrent properties on the merged tag stream, bound into the ingress top

`timescale 1ns/100ps

module igr_assertions #(
  parameter int NUM_PORTS = 4,
  parameter int MAX_LEN   = 64
) (
  input logic                           ingress_clock,
  input logic                           reset,
  input logic                           tag_valid,
  input logic [igr_cfg_pkg::PORT_W-1:0] tag_src,
  input logic [igr_cfg_pkg::LEN_W-1:0]  tag_len,
  input logic                           tag_err,
  input logic [15:0]                    tag_drops
);

  // Output quiet while reset is held
  a_quiet_in_reset: assert property (@(posedge ingress_clock) reset |=> !tag_valid)
    else $error("tag_valid high during reset");

  // Source must name a real port
  a_src_range: assert property (@(posedge ingress_clock) disable iff (reset)
    tag_valid |-> (int'(tag_src) < NUM_PORTS))
    else $error("tag_src out of range");

  // Clean packets carry a legal length
  a_len_range: assert property (@(posedge ingress_clock) disable iff (reset)
    (tag_valid && !tag_err) |-> (tag_len != '0 && int'(tag_len) <= MAX_LEN))
    else $error("clean tag with illegal len");

  // Drop total only ever grows
  a_drops_mono: assert property (@(posedge ingress_clock) disable iff (reset)
    !reset |=> (tag_drops >= $past(tag_drops)))
    else $error("tag_drops decreased");

endmodule

bind igr_top igr_assertions #(
  .NUM_PORTS (NUM_PORTS),
  .MAX_LEN   (MAX_LEN)
) i_assertions (
  .ingress_clock (ingress_clock),
  .reset         (reset),
  .tag_valid     (tag_valid),
  .tag_src       (tag_src),
  .tag_len       (tag_len),
  .tag_err       (tag_err),
  .tag_drops     (tag_drops)
);

//--- rtl/igr_top.sv
// Ingress front end top
// One framing parser and tag queue per receive port, merged into a
// single tag stream by a round-robin arbiter

`timescale 1ns/100ps

module igr_top #(
  parameter int NUM_PORTS  = 4,
  parameter int MAX_LEN    = 64,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                          ingress_clock,
  input  logic                                          reset,
  // Receive ports
  input  logic [NUM_PORTS-1:0]                          rx_valid,
  input  logic [NUM_PORTS-1:0]                          rx_sop,
  input  logic [NUM_PORTS-1:0]                          rx_eop,
  input  logic [NUM_PORTS-1:0][igr_cfg_pkg::DATA_W-1:0] rx_data,
  // Merged tag output
  output logic                                          tag_valid,
  output logic [igr_cfg_pkg::PORT_W-1:0]                tag_src,
  output logic [igr_cfg_pkg::PORT_W-1:0]                tag_dst,
  output logic [igr_cfg_pkg::LEN_W-1:0]                 tag_len,
  output logic                                          tag_err,
  output logic [15:0]                                   tag_drops
);

  import igr_types_pkg::*;

  igr_tag_t             parsed_tag [NUM_PORTS];
  logic [NUM_PORTS-1:0] parsed_push;
  logic [NUM_PORTS-1:0] q_drop;

  // Queue heads toward the arbiter
  igr_tag_if tag_q [NUM_PORTS] ();

  // ==========================================================
  // Per-port parser and queue
  // ==========================================================
  for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
    igr_rx_parser #(
      .MAX_LEN (MAX_LEN),
      .PORT_ID (g)
    ) u_parser (
      .ingress_clock (ingress_clock),
      .reset         (reset),
      .rx_valid      (rx_valid[g]),
      .rx_sop        (rx_sop[g]),
      .rx_eop        (rx_eop[g]),
      .rx_data       (rx_data[g]),
      .tag_push      (parsed_push[g]),
      .tag           (parsed_tag[g])
    );

    igr_tag_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .ingress_clock (ingress_clock),
      .reset         (reset),
      .tag_push      (parsed_push[g]),
      .tag_in        (parsed_tag[g]),
      .out           (tag_q[g]),
      .drop          (q_drop[g])
    );
  end

  // Merge
  igr_tag_arb #(
    .NUM_PORTS (NUM_PORTS)
  ) u_arb (
    .ingress_clock (ingress_clock),
    .reset         (reset),
    .q             (tag_q),
    .drops         (q_drop),
    .tag_valid     (tag_valid),
    .tag_src       (tag_src),
    .tag_dst       (tag_dst),
    .tag_len       (tag_len),
    .tag_err       (tag_err),
    .tag_drops     (tag_drops)
  );

endmodule

//--- rtl/igr_tag_arb.sv
// Round-robin tag merge
// Pops at most one non-empty port queue per cycle, registers its tag
// onto the output and keeps a saturating total of queue drops

`timescale 1ns/100ps

module igr_tag_arb #(
  parameter int NUM_PORTS = 4
) (
  input  logic                           ingress_clock,
  input  logic                           reset,
  igr_tag_if.consumer                    q [NUM_PORTS],
  input  logic [NUM_PORTS-1:0]           drops,
  output logic                           tag_valid,
  output logic [igr_cfg_pkg::PORT_W-1:0] tag_src,
  output logic [igr_cfg_pkg::PORT_W-1:0] tag_dst,
  output logic [igr_cfg_pkg::LEN_W-1:0]  tag_len,
  output logic                           tag_err,
  output logic [15:0]                    tag_drops
);

  import igr_types_pkg::*;

  localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int SUM_W = $clog2(NUM_PORTS + 1);

  logic [NUM_PORTS-1:0] req;
  logic [NUM_PORTS-1:0] grant;
  igr_tag_t             heads [NUM_PORTS];
  logic [IDX_W-1:0]     last;
  logic [IDX_W-1:0]     grant_idx;
  logic                 grant_any;
  logic [SUM_W-1:0]     drop_sum;
  logic [16:0]          drop_total;

  // Flatten the queue interfaces
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_q
    assign req[i]   = q[i].valid;
    assign heads[i] = q[i].tag;
    assign q[i].pop = grant[i];
  end

  // ==========================================================
  // Round-robin pick, starting after the last grant
  // ==========================================================
  always_comb begin
    int unsigned idx;
    grant     = '0;
    grant_idx = last;
    grant_any = 1'b0;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(last) + k) % NUM_PORTS;
      if (!grant_any && req[idx]) begin
        grant_any  = 1'b1;
        grant_idx  = IDX_W'(idx);
        grant[idx] = 1'b1;
      end
    end
  end

  always_ff @(posedge ingress_clock) begin
    if (reset) begin
      tag_valid <= 1'b0;
      // Port 0 wins first after reset
      last      <= IDX_W'(NUM_PORTS - 1);
    end else begin
      tag_valid <= grant_any;
      if (grant_any) begin
        last <= grant_idx;
      end
    end
  end

  // Output tag payload
  always_ff @(posedge ingress_clock) begin
    if (grant_any) begin
      tag_src <= heads[grant_idx].src;
      tag_dst <= heads[grant_idx].dst;
      tag_len <= heads[grant_idx].len;
      tag_err <= heads[grant_idx].err;
    end
  end

  // ==========================================================
  // Drop counter
  // ==========================================================
  always_comb begin
    drop_sum = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      drop_sum = drop_sum + SUM_W'(drops[k]);
    end
  end

  assign drop_total = {1'b0, tag_drops} + 17'(drop_sum);

  always_ff @(posedge ingress_clock) begin
    if (reset) begin
      tag_drops <= '0;
    end else if (drop_total[16]) begin
      // Saturate
      tag_drops <= '1;
    end else begin
      tag_drops <= drop_total[15:0];
    end
  end

endmodule

//--- rtl/igr_tag_fifo.sv
// Per-port tag queue
// Small circular buffer of tags; a push into a full queue is dropped
// and reported with a one-cycle drop strobe

`timescale 1ns/100ps

module igr_tag_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    ingress_clock,
  input  logic                    reset,
  input  logic                    tag_push,
  input  igr_types_pkg::igr_tag_t tag_in,
  igr_tag_if.producer             out,
  output logic                    drop
);

  import igr_types_pkg::*;

  // Depth is a power of two, so pointers wrap on their own
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  igr_tag_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign do_push = tag_push && !full;
  assign do_pop  = out.pop && (count != '0);

  // Head of queue
  assign out.tag   = mem[rd_ptr];
  assign out.empty = (count == '0);

  // ==========================================================
  // Pointers, fill count and drop strobe
  // ==========================================================
  always_ff @(posedge ingress_clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      drop   <= 1'b0;
    end else begin
      drop <= tag_push && full;
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      unique case ({do_push, do_pop})
        2'b10:   count <= count + (PTR_W + 1)'(1);
        2'b01:   count <= count - (PTR_W + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge ingress_clock) begin
    if (do_push) begin
      mem[wr_ptr] <= tag_in;
    end
  end

endmodule

//--- rtl/igr_rx_parser.sv
// Receive framing parser for one port
// Tracks sop/eop framing, counts words and emits one tag per packet,
// flagging orphan eop, nested sop and overlong packets as errors

`timescale 1ns/100ps

module igr_rx_parser #(
  parameter int MAX_LEN = 64,
  parameter int PORT_ID = 0
) (
  input  logic                           ingress_clock,
  input  logic                           reset,
  input  logic                           rx_valid,
  input  logic                           rx_sop,
  input  logic                           rx_eop,
  input  logic [igr_cfg_pkg::DATA_W-1:0] rx_data,
  output logic                           tag_push,
  output igr_types_pkg::igr_tag_t        tag
);

  import igr_cfg_pkg::*;
  import igr_types_pkg::*;

  localparam logic [LEN_W-1:0]  MAX_LEN_V = LEN_W'(MAX_LEN);
  localparam logic [PORT_W-1:0] SRC_ID    = PORT_W'(PORT_ID);

  igr_parse_state_e  state;
  igr_parse_state_e  state_next;
  logic [PORT_W-1:0] cur_dst;
  logic [PORT_W-1:0] cur_dst_next;
  logic [LEN_W-1:0]  cur_len;
  logic [LEN_W-1:0]  cur_len_next;
  logic              push_next;
  igr_tag_t          tag_next;
  logic [PORT_W-1:0] rx_dst;
  logic              at_max;

  // Destination field of the current word
  assign rx_dst = rx_data[DST_LSB +: PORT_W];

  // No room for another word; also true all through PS_DISCARD
  assign at_max = (cur_len >= MAX_LEN_V);

  // ==========================================================
  // Next state and tag
  // ==========================================================
  always_comb begin
    state_next   = state;
    cur_dst_next = cur_dst;
    cur_len_next = cur_len;
    push_next    = 1'b0;
    // Default tag describes the open packet
    tag_next.src = SRC_ID;
    tag_next.dst = cur_dst;
    tag_next.len = cur_len;
    tag_next.err = 1'b0;

    if (rx_valid) begin
      unique case (state)
        PS_IDLE: begin
          if (rx_sop && rx_eop) begin
            // Single-word packet
            push_next    = 1'b1;
            tag_next.dst = rx_dst;
            tag_next.len = LEN_W'(1);
          end else if (rx_sop) begin
            state_next   = PS_IN_PKT;
            cur_dst_next = rx_dst;
            cur_len_next = LEN_W'(1);
          end else if (rx_eop) begin
            // Orphan eop
            push_next    = 1'b1;
            tag_next.dst = '0;
            tag_next.len = LEN_W'(1);
            tag_next.err = 1'b1;
          end
          // Plain words outside a packet are ignored
        end

        PS_IN_PKT, PS_DISCARD: begin
          if (rx_sop) begin
            // Nested sop closes the open packet as an error.
            // If it also carries eop the new one-word packet gets no tag,
            // since the push slot is taken by the old packet
            push_next    = 1'b1;
            tag_next.err = 1'b1;
            cur_dst_next = rx_dst;
            cur_len_next = LEN_W'(1);
            state_next   = rx_eop ? PS_IDLE : PS_IN_PKT;
          end else if (at_max) begin
            // Overrun, length pinned at MAX_LEN
            cur_len_next = MAX_LEN_V;
            if (rx_eop) begin
              push_next    = 1'b1;
              tag_next.len = MAX_LEN_V;
              tag_next.err = 1'b1;
              state_next   = PS_IDLE;
            end else begin
              state_next   = PS_DISCARD;
            end
          end else begin
            cur_len_next = cur_len + LEN_W'(1);
            if (rx_eop) begin
              push_next    = 1'b1;
              tag_next.len = cur_len + LEN_W'(1);
              state_next   = PS_IDLE;
            end
          end
        end

        default: state_next = PS_IDLE;
      endcase
    end
  end

  // ==========================================================
  // Registers
  // ==========================================================
  always_ff @(posedge ingress_clock) begin
    if (reset) begin
      state    <= PS_IDLE;
      tag_push <= 1'b0;
    end else begin
      state    <= state_next;
      tag_push <= push_next;
    end
  end

  // Packet context and tag payload
  always_ff @(posedge ingress_clock) begin
    cur_dst <= cur_dst_next;
    cur_len <= cur_len_next;
    tag     <= tag_next;
  end

endmodule

//--- rtl/igr_tag_if.sv
// Tag queue interface
// Carries the head of a tag queue toward the arbiter, with a pop strobe back

`timescale 1ns/100ps

interface igr_tag_if;

  import igr_types_pkg::*;

  // Head of queue is a real tag
  logic     valid;
  // Tag at the head of the queue
  igr_tag_t tag;
  // Take the head tag at the next clock edge
  logic     pop;
  // Queue holds nothing
  logic     empty;

  // A tag is on offer whenever the queue is not empty
  assign valid = ~empty;

  // Queue side
  modport producer (
    output tag,
    output empty,
    input  pop
  );

  // Arbiter side
  modport consumer (
    input  valid,
    input  tag,
    input  empty,
    output pop
  );

endinterface

//--- rtl/igr_types_pkg.sv
// Ingress types package
// Tag record passed from parser to output, and parser FSM states

package igr_types_pkg;

  // ==========================================================
  // Packet tag
  // ==========================================================

  // One tag per received packet
  typedef struct packed {
    // Receive port the packet came in on
    logic [igr_cfg_pkg::PORT_W-1:0] src;
    // Destination port taken from the first word
    logic [igr_cfg_pkg::PORT_W-1:0] dst;
    // Word count, saturates at MAX_LEN
    logic [igr_cfg_pkg::LEN_W-1:0]  len;
    // Framing error seen on this packet
    logic                           err;
  } igr_tag_t;

  // ==========================================================
  // Parser FSM
  // ==========================================================

  typedef enum logic [1:0] {
    // Between packets
    PS_IDLE    = 2'd0,
    // Inside a packet, counting words
    PS_IN_PKT  = 2'd1,
    // Packet overran MAX_LEN, waiting for eop
    PS_DISCARD = 2'd2
  } igr_parse_state_e;

endpackage

//--- rtl/igr_cfg_pkg.sv
// Ingress configuration package
// Widths and field positions shared by the ingress datapath

package igr_cfg_pkg;

  // ==========================================================
  // Receive word
  // ==========================================================

  // Width of one receive word on every port
  localparam int DATA_W = 32;

  // ==========================================================
  // Tag fields
  // ==========================================================

  // Port number width, up to 8 ports
  localparam int PORT_W = 3;

  // Word count width, wide enough for MAX_LEN
  localparam int LEN_W = 8;

  // ==========================================================
  // Header layout
  // ==========================================================

  // Destination field starts here in the first word
  localparam int DST_LSB = 0;

endpackage
